// File: testbench/lsu_input.txt
# kind size(hex) addr(hex) data(hex) test_name expected_data(hex) expected_fault
# sizes follow funct3, only loads use the last two columns
load   2 00000040 00000000 lw_reset         00000013 0
load   0 000001fc 00000000 lb_sign          ffffff82 0
load   4 000001fc 00000000 lbu_zero         00000082 0
load   1 000001f4 00000000 lh_reset         00000080 0
load   5 000003f4 00000000 lhu_reset        00000100 0
store  2 00000080 a1b2c3d4 sw_word          00000000 0
store  0 00000081 000000e5 sb_lane1         00000000 0
store  1 00000082 00008765 sh_upper         00000000 0
load   2 00000080 00000000 lw_merged        8765e5d4 0
load   1 00000082 00000000 lh_upper         ffff8765 0
load   0 00000081 00000000 lb_lane1         ffffffe5 0
load   2 00000042 00000000 lw_misaligned    00000000 1
load   1 00000043 00000000 lh_odd           00000000 1
load   3 00000048 00000000 size_unknown     00000000 1
store  1 00000045 0000ffff sh_odd           00000000 0
load   2 00000044 00000000 lw_after_fault   00000014 0
store  2 00000100 11223344 sw_kept          00000000 0
commit 2 00000100 11223344 cm_kept          00000000 0
store  2 00000104 55667788 sw_dropped       00000000 0
load   2 00000104 00000000 lw_spec          55667788 0
flush  0 00000000 00000000 flush_first      00000000 0
commit 2 00000200 cafe0001 cm_run0          00000000 0
commit 0 00000205 000000a5 cm_run1          00000000 0
commit 1 0000020a 00005a5a cm_run2          00000000 0
commit 2 0000020c 0badf00d cm_run3          00000000 0
load   2 00000100 00000000 lw_kept          11223344 0
load   2 00000104 00000000 lw_undone        00000044 0
load   2 00000080 00000000 lw_merge_undone  00000023 0
load   2 00000200 00000000 lw_not_restored  00000083 0
flush  0 00000000 00000000 flush_second     00000000 0
load   2 00000200 00000000 lw_run0          cafe0001 0
load   2 00000204 00000000 lw_run1          0000a584 0
load   2 00000208 00000000 lw_run2          5a5a0085 0
load   2 0000020c 00000000 lw_run3          0badf00d 0
load   2 00000100 00000000 lw_still_kept    11223344 0

// File: lsu_mem_top.f
+incdir+include
verilog/lsu_pkg.sv
verilog/lsu_queue.sv
verilog/load_align.sv
verilog/restore_walker.sv
verilog/spec_data_mem.sv
verilog/lsu_mem_top.sv
testbench/lsu_checker.sv
testbench/tb_lsu_mem.sv

// File: Makefile
SOURCES := lsu_mem_top.f include/lsu_cfg.svh $(wildcard verilog/*.sv testbench/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vtb_lsu_mem: $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal -j 0 --top-module tb_lsu_mem -f lsu_mem_top.f

run: obj_dir/Vtb_lsu_mem
	@out="$$(./obj_dir/Vtb_lsu_mem)"; echo "$$out"; \
	echo "$$out" | grep -qx "Test completed successfully"

clean:
	rm -rf obj_dir

// File: testbench/tb_lsu_mem.sv
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module tb_lsu_mem;

    typedef struct packed {
        logic [1:0]  kind;  // 0 load, 1 store, 2 commit, 3 flush
        logic [2:0]  size;
        logic [31:0] addr;
        logic [31:0] data;
    } op_t;

    logic                clk = 1'b0;
    logic                reset;
    logic                req_valid;
    logic                req_ready;
    lsu_pkg::ls_req_t    req;
    logic                commit_valid;
    logic                commit_ready;
    lsu_pkg::commit_t    commit;
    logic                flush;
    logic                resp_valid;
    logic                resp_ready = 1'b0;
    lsu_pkg::load_resp_t resp;

    op_t         ops[$];
    bit          ops_loaded = 1'b0;
    int          bad_lines  = 0;
    int          loads_sent = 0;
    int          resp_taken = 0;
    logic [31:0] lcg_state  = 32'h532e_44e0;
    int          checked;
    int          errors;
    int          pending;

    always #20 clk = ~clk;

    lsu_mem_top UUT (
        .clk          (clk),
        .reset        (reset),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .req          (req),
        .commit_valid (commit_valid),
        .commit_ready (commit_ready),
        .commit       (commit),
        .flush        (flush),
        .resp_valid   (resp_valid),
        .resp_ready   (resp_ready),
        .resp         (resp)
    );

    lsu_checker lsu_checker (
        .clk          (clk),
        .reset        (reset),
        .flush        (flush),
        .req_ready    (req_ready),
        .commit_ready (commit_ready),
        .resp_valid   (resp_valid),
        .resp_ready   (resp_ready),
        .resp         (resp),
        .checked      (checked),
        .errors       (errors),
        .pending      (pending)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Random back-pressure on the response port
    always @(posedge clk) begin
        if (reset) begin
            resp_ready <= 1'b0;
        end else begin
            lcg_state  = lcg_next(lcg_state);
            resp_ready <= (lcg_state[17:16] != 2'b00);  // Ready about 3 cycles in 4
        end
    end

    always @(posedge clk) begin
        if (!reset && resp_valid && resp_ready) resp_taken <= resp_taken + 1;
    end

    task automatic read_operations();
        int    fd;
        string line;
        string kind;
        string name;
        op_t   op;
        fd = $fopen("testbench/lsu_input.txt", "r");
        if (fd == 0) begin
            $display("Cannot open testbench/lsu_input.txt");
            bad_lines++;
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) != 0 &&
                    $sscanf(line, "%s %h %h %h %s", kind, op.size, op.addr, op.data, name) == 5) begin
                    if (kind == "load") op.kind = 2'd0;
                    else if (kind == "store") op.kind = 2'd1;
                    else if (kind == "commit") op.kind = 2'd2;
                    else if (kind == "flush") op.kind = 2'd3;
                    else begin
                        $display("Unknown operation kind %s in test %s", kind, name);
                        bad_lines++;
                    end
                    ops.push_back(op);
                end
            end
            $fclose(fd);
        end
        ops_loaded = 1'b1;
    endtask

    task automatic send_request(input int idx, input op_t op);
        lsu_pkg::ls_req_t r;
        r.is_store = (op.kind == 2'd1);
        r.size     = op.size;
        r.addr     = op.addr;
        r.wdata    = op.data;
        r.inst_num = `LSU_TAG_BITS'(idx);
        r.phy_reg  = `LSU_PHY_BITS'(idx * 7 + 1);  // Line number scrambled into a register
        @(posedge clk);
        req_valid <= 1'b1;
        req       <= r;
        @(posedge clk);
        while (!req_ready) @(posedge clk);
        req_valid <= 1'b0;
        if (!r.is_store) loads_sent++;
    endtask

    task automatic send_commit(input op_t op);
        @(posedge clk);
        commit_valid <= 1'b1;
        commit       <= '{addr: op.addr, size: op.size, wdata: op.data};
        @(posedge clk);
        while (!commit_ready) @(posedge clk);
        commit_valid <= 1'b0;
    endtask

    task automatic wait_for_responses();
        @(posedge clk);
        while (resp_taken != loads_sent) @(posedge clk);
    endtask

    // In-flight loads would be dropped by the flush
    task automatic pulse_flush();
        wait_for_responses();
        repeat (2) @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
    endtask

    initial begin
        reset        = 1'b1;
        req_valid    = 1'b0;
        req          = '0;
        commit_valid = 1'b0;
        commit       = '0;
        flush        = 1'b0;
        read_operations();
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        foreach (ops[i]) begin
            case (ops[i].kind)
                2'd2:    send_commit(ops[i]);
                2'd3:    pulse_flush();  // Later requests stall on req_ready until restore ends
                default: send_request(i, ops[i]);
            endcase
        end
        wait_for_responses();
        repeat (2) @(posedge clk);
        if (pending != 0) $display("%0d expected load responses never arrived", pending);
        $display("Summary: %0d loads checked, %0d errors, %0d missing, %0d bad lines",
                 checked, errors, pending, bad_lines);
        if (errors == 0 && pending == 0 && bad_lines == 0 && checked > 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Each line may cost a full restore sweep
    initial begin
        wait (ops_loaded);
        #((ops.size() + 1) * (`LSU_MEM_WORDS + 20) * 40);
        $display("Watchdog expired with %0d of %0d loads answered", resp_taken, loads_sent);
        $display("Test failed");
        $finish;
    end

endmodule

// File: testbench/lsu_checker.sv
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_checker (
    input  logic                clk,
    input  logic                reset,
    input  logic                flush,
    input  logic                req_ready,
    input  logic                commit_ready,
    input  logic                resp_valid,
    input  logic                resp_ready,
    input  lsu_pkg::load_resp_t resp,
    output int                  checked,
    output int                  errors,
    output int                  pending
);

    lsu_pkg::load_resp_t expect_q[$];  // Load results in issue order
    string               name_q[$];
    string               flush_q[$];   // Names of the flush lines
    logic                reset_seen = 1'b0;  // Reset at the previous edge
    logic                restoring  = 1'b0;
    int                  ready_low  = 0;

    initial begin
        int                  fd;
        int                  idx;
        string               line;
        string               kind;
        string               name;
        logic [2:0]          size;
        logic [31:0]         addr;
        logic [31:0]         data;
        logic [31:0]         exp_data;
        logic                exp_fault;
        lsu_pkg::load_resp_t exp;
        checked = 0;
        errors  = 0;
        idx     = 0;
        fd = $fopen("testbench/lsu_input.txt", "r");
        if (fd == 0) begin
            $display("Checker cannot open testbench/lsu_input.txt");
            errors = 1;
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) != 0 &&
                    $sscanf(line, "%s %h %h %h %s %h %h", kind, size, addr, data, name,
                            exp_data, exp_fault) == 7) begin
                    if (kind == "load") begin
                        exp.data     = exp_data;
                        exp.fault    = exp_fault;
                        exp.inst_num = `LSU_TAG_BITS'(idx);  // Tag is the operation number
                        exp.phy_reg  = `LSU_PHY_BITS'(idx * 7 + 1);
                        expect_q.push_back(exp);
                        name_q.push_back(name);
                    end else if (kind == "flush") begin
                        flush_q.push_back(name);
                    end
                    idx++;
                end
            end
            $fclose(fd);
        end
        pending = expect_q.size();
    end

    always @(posedge clk) begin
        lsu_pkg::load_resp_t exp;
        string               name;
        if (!reset && resp_valid && resp_ready) begin
            if (expect_q.size() == 0) begin
                $display("A load response for inst %0d arrived when no load was expected",
                         resp.inst_num);
                errors++;
            end else begin
                exp  = expect_q.pop_front();
                name = name_q.pop_front();
                checked++;
                if (resp !== exp) begin
                    $display("ERROR %s: expected data=%h fault=%b inst=%0d phy=%0d, %s",
                             name, exp.data, exp.fault, exp.inst_num, exp.phy_reg,
                             $sformatf("actual data=%h fault=%b inst=%0d phy=%0d",
                                       resp.data, resp.fault, resp.inst_num, resp.phy_reg));
                    errors++;
                end else begin
                    $display("PASS  %s: data=%h fault=%b", name, resp.data, resp.fault);
                end
            end
            pending = expect_q.size();
        end
        // Both queues open on the first cycle out of reset
        if (reset_seen && !reset) begin
            if (req_ready !== 1'b1 || commit_ready !== 1'b1) begin
                $display("ERROR ready_after_reset: expected req_ready=1 commit_ready=1, %s",
                         $sformatf("actual req_ready=%b commit_ready=%b",
                                   req_ready, commit_ready));
                errors++;
            end else begin
                $display("PASS  ready_after_reset");
            end
        end
        reset_seen = reset;
        // Closed for the flush cycle plus one cycle per restored word
        if (!reset && flush) begin
            restoring = 1'b1;
            ready_low = 0;
        end
        if (restoring) begin
            if (!req_ready) begin
                ready_low++;
            end else begin
                restoring = 1'b0;
                if (flush_q.size() != 0) begin
                    name = flush_q.pop_front();
                end else begin
                    name = "flush";
                end
                if (ready_low != `LSU_MEM_WORDS + 1) begin
                    $display("ERROR %s: expected req_ready low for %0d cycles, actual %0d",
                             name, `LSU_MEM_WORDS + 1, ready_low);
                    errors++;
                end else begin
                    $display("PASS  %s: req_ready low for %0d cycles", name, ready_low);
                end
            end
        end
    end

endmodule

// File: verilog/lsu_mem_top.sv
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_mem_top (
    input  logic                clk,
    input  logic                reset,
    input  logic                req_valid,
    output logic                req_ready,
    input  lsu_pkg::ls_req_t    req,
    input  logic                commit_valid,
    output logic                commit_ready,
    input  lsu_pkg::commit_t    commit,
    input  logic                flush,
    output logic                resp_valid,
    input  logic                resp_ready,
    output lsu_pkg::load_resp_t resp
);

    logic                       q_req_valid;
    logic                       q_req_ready;
    lsu_pkg::ls_req_t           q_req;
    logic                       q_commit_valid;
    logic                       q_commit_ready;
    lsu_pkg::commit_t           q_commit;
    logic                       restore_busy;
    logic [`LSU_WADDR_BITS-1:0] restore_waddr;

    // Held empty and closed for the whole restore
    lsu_queue #(.payload_t(lsu_pkg::ls_req_t)) u_req_queue (
        .clk       (clk),
        .reset     (reset),
        .clear     (flush || restore_busy),
        .in_valid  (req_valid),
        .in_ready  (req_ready),
        .in_data   (req),
        .out_valid (q_req_valid),
        .out_ready (q_req_ready),
        .out_data  (q_req)
    );

    // Retired stores survive a flush
    lsu_queue #(.payload_t(lsu_pkg::commit_t)) u_commit_queue (
        .clk       (clk),
        .reset     (reset),
        .clear     (1'b0),
        .in_valid  (commit_valid),
        .in_ready  (commit_ready),
        .in_data   (commit),
        .out_valid (q_commit_valid),
        .out_ready (q_commit_ready),
        .out_data  (q_commit)
    );

    spec_data_mem u_mem (
        .clk           (clk),
        .reset         (reset),
        .flush         (flush),
        .req_valid     (q_req_valid),
        .req_ready     (q_req_ready),
        .req           (q_req),
        .commit_valid  (q_commit_valid),
        .commit_ready  (q_commit_ready),
        .commit        (q_commit),
        .restore_busy  (restore_busy),
        .restore_waddr (restore_waddr),
        .resp_valid    (resp_valid),
        .resp_ready    (resp_ready),
        .resp          (resp)
    );

    restore_walker u_walker (
        .clk   (clk),
        .reset (reset),
        .flush (flush),
        .busy  (restore_busy),
        .waddr (restore_waddr)
    );

endmodule

// File: verilog/spec_data_mem.sv
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module spec_data_mem (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       flush,
    input  logic                       req_valid,
    output logic                       req_ready,
    input  lsu_pkg::ls_req_t           req,
    input  logic                       commit_valid,
    output logic                       commit_ready,
    input  lsu_pkg::commit_t           commit,
    input  logic                       restore_busy,
    input  logic [`LSU_WADDR_BITS-1:0] restore_waddr,
    output logic                       resp_valid,
    input  logic                       resp_ready,
    output lsu_pkg::load_resp_t        resp
);

    logic [31:0] spec_mem   [`LSU_MEM_WORDS];  // Seen by executing loads and stores
    logic [31:0] commit_mem [`LSU_MEM_WORDS];  // Architectural copy

    logic [`LSU_WADDR_BITS-1:0] req_widx;
    logic [`LSU_WADDR_BITS-1:0] commit_widx;
    logic                       req_pop;
    logic                       load_pop;
    logic                       commit_pop;
    logic [31:0]                req_load_data;
    logic [31:0]                req_store_word;
    logic [3:0]                 req_be;
    logic                       req_misaligned;
    logic [31:0]                commit_store_word;
    logic [3:0]                 commit_be;

    assign req_widx    = req.addr[`LSU_WADDR_BITS+1:2];
    assign commit_widx = commit.addr[`LSU_WADDR_BITS+1:2];

    // Loads also need room in the response register
    assign req_ready    = !restore_busy && !flush &&
                          (req.is_store || !resp_valid || resp_ready);
    assign req_pop      = req_valid && req_ready;
    assign load_pop     = req_pop && !req.is_store;
    assign commit_ready = !restore_busy;
    assign commit_pop   = commit_valid && commit_ready;

    load_align u_req_align (
        .size       (req.size),
        .byte_off   (req.addr[1:0]),
        .word_in    (spec_mem[req_widx]),
        .store_data (req.wdata),
        .load_data  (req_load_data),
        .store_word (req_store_word),
        .byte_en    (req_be),
        .misaligned (req_misaligned)
    );

    // Only the store lanes matter on the commit side
    load_align u_commit_align (
        .size       (commit.size),
        .byte_off   (commit.addr[1:0]),
        .word_in    (commit_mem[commit_widx]),
        .store_data (commit.wdata),
        .load_data  (),
        .store_word (commit_store_word),
        .byte_en    (commit_be),
        .misaligned ()
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `LSU_MEM_WORDS; i++) begin
                spec_mem[i]   <= 32'(i + 3);
                commit_mem[i] <= 32'(i + 3);
            end
        end else begin
            if (restore_busy) begin
                spec_mem[restore_waddr] <= commit_mem[restore_waddr];  // Rebuild one word
            end else if (req_pop && req.is_store) begin
                for (int b = 0; b < 4; b++) begin
                    if (req_be[b]) spec_mem[req_widx][8*b +: 8] <= req_store_word[8*b +: 8];
                end
            end
            if (commit_pop) begin
                for (int b = 0; b < 4; b++) begin
                    if (commit_be[b]) commit_mem[commit_widx][8*b +: 8] <= commit_store_word[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            resp_valid <= 1'b0;  // Wrong-path load is dropped
        end else if (load_pop) begin
            resp_valid <= 1'b1;
        end else if (resp_ready) begin
            resp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load_pop) begin
            resp.data     <= req_load_data;  // Already zero on a fault
            resp.inst_num <= req.inst_num;
            resp.phy_reg  <= req.phy_reg;
            resp.fault    <= req_misaligned;
        end
    end

    // Speculative stores stay out of the committed copy
    a_store_spares_commit_copy: assert property (@(posedge clk) disable iff (reset)
        (req_pop && req.is_store && !commit_pop) |=>
            (commit_mem[$past(req_widx)] == $past(commit_mem[req_widx])));

    // Back-pressure holds the response unchanged
    a_resp_held: assert property (@(posedge clk) disable iff (reset)
        (resp_valid && !resp_ready && !flush) |=> (resp_valid && $stable(resp)));

endmodule

// File: verilog/restore_walker.sv
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module restore_walker (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       flush,
    output logic                       busy,
    output logic [`LSU_WADDR_BITS-1:0] waddr
);

    localparam logic [`LSU_WADDR_BITS-1:0] LAST_WORD = `LSU_WADDR_BITS'(`LSU_MEM_WORDS - 1);

    // One word per cycle, busy spans the whole sweep
    always_ff @(posedge clk) begin
        if (reset) begin
            busy  <= 1'b0;
            waddr <= '0;
        end else if (flush) begin
            busy  <= 1'b1;  // Sweep starts at word 0 next cycle
            waddr <= '0;
        end else if (busy) begin
            if (waddr == LAST_WORD) begin
                busy  <= 1'b0;
                waddr <= '0;
            end else begin
                waddr <= waddr + 1'b1;
            end
        end
    end

    // The core must not raise a second exception mid-restore
    a_no_flush_while_busy: assert property (@(posedge clk) disable iff (reset)
        flush |-> !busy);

endmodule

// File: verilog/load_align.sv
`timescale 1ns/1ps

module load_align (
    input  lsu_pkg::ls_size_t size,
    input  logic [1:0]        byte_off,
    input  logic [31:0]       word_in,
    input  logic [31:0]       store_data,
    output logic [31:0]       load_data,
    output logic [31:0]       store_word,
    output logic [3:0]        byte_en,
    output logic              misaligned
);

    logic [7:0]  sel_byte;
    logic [15:0] sel_half;
    logic        sign_ext;
    logic [31:0] ext_data;
    logic [3:0]  lanes;

    assign sel_byte = word_in[{byte_off, 3'b000} +: 8];
    assign sel_half = byte_off[1] ? word_in[31:16] : word_in[15:0];
    assign sign_ext = !size[2];  // funct3 bit 2 marks unsigned

    always_comb begin
        ext_data   = '0;
        store_word = store_data;
        lanes      = 4'b0000;
        misaligned = 1'b0;
        case (size)
            lsu_pkg::LS_SIZE_B, lsu_pkg::LS_SIZE_BU: begin
                ext_data   = {{24{sign_ext & sel_byte[7]}}, sel_byte};  // Sign of the byte itself
                store_word = {4{store_data[7:0]}};
                lanes      = 4'b0001 << byte_off;
            end
            lsu_pkg::LS_SIZE_H, lsu_pkg::LS_SIZE_HU: begin
                misaligned = byte_off[0];
                ext_data   = {{16{sign_ext & sel_half[15]}}, sel_half};
                store_word = {2{store_data[15:0]}};
                lanes      = byte_off[1] ? 4'b1100 : 4'b0011;
            end
            lsu_pkg::LS_SIZE_W: begin
                misaligned = |byte_off;
                ext_data   = word_in;
                lanes      = 4'b1111;
            end
            default: misaligned = 1'b1;  // Unknown size code
        endcase
        load_data = misaligned ? 32'd0 : ext_data;
        byte_en   = misaligned ? 4'b0000 : lanes;  // Faulting stores write nothing
    end

endmodule

// File: verilog/lsu_queue.sv
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_queue #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     clear,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    localparam int DEPTH    = `LSU_QUEUE_DEPTH;
    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    payload_t            slots [DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;
    logic                push;
    logic                pop;

    function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
        return (ptr == PTR_BITS'(DEPTH - 1)) ? '0 : ptr + 1'b1;  // Wrap at depth
    endfunction

    assign in_ready  = (count != CNT_BITS'(DEPTH)) && !clear;  // Nothing lands while clearing
    assign out_valid = (count != '0);
    assign out_data  = slots[rd_ptr];
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= next_ptr(wr_ptr);
            if (pop)  rd_ptr <= next_ptr(rd_ptr);
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Idle or push and pop together
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) slots[wr_ptr] <= in_data;
    end

    // A write taken when full would overwrite the oldest entry
    a_no_write_when_full: assert property (@(posedge clk) disable iff (reset)
        push |-> (count == '0 || wr_ptr != rd_ptr));

    a_count_in_range: assert property (@(posedge clk) disable iff (reset)
        count <= CNT_BITS'(DEPTH));

endmodule

// File: verilog/lsu_pkg.sv
`include "lsu_cfg.svh"

package lsu_pkg;

    // Access size, same encoding as funct3
    typedef logic [2:0] ls_size_t;

    localparam ls_size_t LS_SIZE_B  = 3'b000;  // LB / SB
    localparam ls_size_t LS_SIZE_H  = 3'b001;  // LH / SH
    localparam ls_size_t LS_SIZE_W  = 3'b010;  // LW / SW
    localparam ls_size_t LS_SIZE_BU = 3'b100;  // LBU
    localparam ls_size_t LS_SIZE_HU = 3'b101;  // LHU

    // One load or store from the issue side
    typedef struct packed {
        logic                       is_store;
        ls_size_t                   size;
        logic [31:0]                addr;      // Byte address
        logic [31:0]                wdata;     // Ignored for loads
        logic [`LSU_TAG_BITS-1:0]   inst_num;
        logic [`LSU_PHY_BITS-1:0]   phy_reg;
    } ls_req_t;

    // Load result back to the core
    typedef struct packed {
        logic [31:0]                data;
        logic [`LSU_TAG_BITS-1:0]   inst_num;
        logic [`LSU_PHY_BITS-1:0]   phy_reg;
        logic                       fault;     // Misaligned or bad size
    } load_resp_t;

    // Store retired by the ROB
    typedef struct packed {
        logic [31:0]                addr;
        ls_size_t                   size;
        logic [31:0]                wdata;
    } commit_t;

endpackage

// File: include/lsu_cfg.svh
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// Memory geometry, both copies share it
`define LSU_MEM_WORDS   256
`define LSU_WADDR_BITS  8

// Entries in the request and commit queues
`define LSU_QUEUE_DEPTH 4

// Tag widths carried with each load
`define LSU_TAG_BITS    32
`define LSU_PHY_BITS    8

`endif
